/* logic/spi_bus_pkg.sv */
package spi_bus_pkg;

    // ------------------------------
    // Wire-side widths
    // ------------------------------
    localparam int MAX_BYTES = 4;                   // Buffer depth in bytes
    localparam int BYTE_W    = 8;
    localparam int ADDR_W    = $clog2(MAX_BYTES);   // Buffer index width
    localparam int LEN_W     = ADDR_W + 1;          // Count 1..MAX_BYTES needs one more bit

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;

    // All three lines driven by the master
    typedef struct packed {
        logic sclk;     // Mode 0, idles low
        logic mosi;
        logic cs_n;     // Single target select
    } spi_bus_t;

endpackage

/* logic/spi_io_pkg.sv */
package spi_io_pkg;

    import spi_bus_pkg::*;

    // ------------------------------
    // Host request and result
    // ------------------------------
    typedef struct packed {
        len_t                  len;    // Bytes to move, 1..MAX_BYTES
        byte_t [MAX_BYTES-1:0] data;   // data[0] goes out first
    } xfer_req_t;

    typedef struct packed {
        len_t                  len;    // Copy of request length
        byte_t [MAX_BYTES-1:0] data;   // data[0] received first
    } xfer_rsp_t;

    // ------------------------------
    // FSM encodings
    // ------------------------------
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_WRITE,      // Fill tx buffer
        SEQ_SEND,       // One-cycle send pulse
        SEQ_WAIT,       // Until io_complete
        SEQ_READ        // Drain rx buffer
    } seq_state_t;

    typedef enum logic [1:0] {
        SH_IDLE,
        SH_LOW,         // sclk low half, mosi settles
        SH_HIGH,        // sclk high half
        SH_DONE         // Trailing low half before cs_n release
    } shift_state_t;

endpackage

/* logic/io_buffer.sv */
`timescale 1ns/1ps

module io_buffer (
    input  logic               pllClk_i,
    // Host side
    input  logic               tx_wr,
    input  spi_bus_pkg::addr_t tx_addr,
    input  spi_bus_pkg::byte_t tx_byte,
    input  logic               rx_rd,
    input  spi_bus_pkg::addr_t rx_addr,
    output spi_bus_pkg::byte_t rx_byte,       // Valid the cycle after rx_rd
    // Shifter side
    input  spi_bus_pkg::addr_t sh_addr,
    input  logic               sh_rx_wr,
    input  spi_bus_pkg::byte_t sh_rx_byte,
    output spi_bus_pkg::byte_t sh_tx_byte
);

    import spi_bus_pkg::*;

    byte_t tx_mem [MAX_BYTES];    // Host writes, shifter reads
    byte_t rx_mem [MAX_BYTES];    // Shifter writes, host reads

    // ------------------------------
    // Write ports
    // ------------------------------
    always_ff @(posedge pllClk_i) begin
        if (tx_wr) begin
            tx_mem[tx_addr] <= tx_byte;
        end
        if (sh_rx_wr) begin
            rx_mem[sh_addr] <= sh_rx_byte;    // Completed byte from the shift engine
        end
    end

    // Registered host read
    always_ff @(posedge pllClk_i) begin
        if (rx_rd) begin
            rx_byte <= rx_mem[rx_addr];
        end
    end

    assign sh_tx_byte = tx_mem[sh_addr];     // Shifter picks it up at byte start

endmodule

/* logic/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter #(
    parameter int SCLK_DIV = 2                    // pllClk_i cycles per sclk half period
) (
    input  logic                  pllClk_i,
    input  logic                  reset_complete,
    input  logic                  send,
    input  spi_bus_pkg::len_t     len,
    input  spi_bus_pkg::byte_t    tx_byte,
    input  logic                  miso,
    output spi_bus_pkg::addr_t    idx,            // Byte being shifted
    output logic                  rx_wr,
    output spi_bus_pkg::byte_t    rx_byte,
    output logic                  io_complete,
    output spi_bus_pkg::spi_bus_t bus
);

    import spi_bus_pkg::*;
    import spi_io_pkg::*;

    localparam int CNT_W = $clog2(SCLK_DIV);

    shift_state_t     state;
    logic [CNT_W-1:0] div_cnt;
    logic [2:0]       bit_cnt;
    logic             sclk_q;
    logic             cs_n_q;
    byte_t            shift_tx;
    byte_t            shift_rx;
    logic             half_end;
    logic             byte_end;
    logic             last_byte;

    assign half_end  = (div_cnt == CNT_W'(SCLK_DIV - 1));
    assign byte_end  = (state == SH_HIGH) && half_end && (bit_cnt == 3'd7);
    assign last_byte = (len_t'(idx) == len - len_t'(1));

    assign rx_wr   = byte_end;                    // Buffer stores at current idx
    assign rx_byte = shift_rx;
    assign bus     = '{sclk: sclk_q, mosi: shift_tx[7], cs_n: cs_n_q};   // MSB first

    // ------------------------------
    // Divider and bit FSM
    // ------------------------------
    always_ff @(posedge pllClk_i) begin
        if (reset_complete) begin
            state       <= SH_IDLE;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            idx         <= '0;
            sclk_q      <= 1'b0;
            cs_n_q      <= 1'b1;
            shift_tx    <= '0;                    // Keeps mosi low
            io_complete <= 1'b0;
        end else begin
            io_complete <= 1'b0;
            if (state == SH_IDLE || half_end) div_cnt <= '0;
            else                              div_cnt <= div_cnt + 1'b1;

            case (state)
                SH_IDLE: begin
                    if (send) begin               // Ignored unless idle
                        cs_n_q  <= 1'b0;
                        idx     <= '0;
                        bit_cnt <= '0;
                        state   <= SH_LOW;
                    end
                end
                SH_LOW: begin
                    if (div_cnt == '0 && bit_cnt == 3'd0) begin
                        shift_tx <= tx_byte;      // New byte at start of its first low half
                    end
                    if (half_end) begin
                        sclk_q <= 1'b1;           // Rising edge
                        state  <= SH_HIGH;
                    end
                end
                SH_HIGH: begin
                    if (half_end) begin
                        sclk_q   <= 1'b0;         // Falling edge, next bit out
                        shift_tx <= {shift_tx[6:0], 1'b0};
                        bit_cnt  <= bit_cnt + 1'b1;
                        state    <= SH_LOW;
                        if (byte_end && last_byte) state <= SH_DONE;
                        else if (byte_end)         idx   <= idx + 1'b1;
                    end
                end
                SH_DONE: begin
                    if (half_end) begin
                        cs_n_q      <= 1'b1;      // Release and flag together
                        io_complete <= 1'b1;
                        state       <= SH_IDLE;
                    end
                end
                default: state <= SH_IDLE;
            endcase
        end
    end

    // Receive shift, sampled with the rising edge
    always_ff @(posedge pllClk_i) begin
        if (state == SH_LOW && half_end) shift_rx <= {shift_rx[6:0], miso};
    end

    // Select released only at the end of the transfer
    a_cs_held: assert property (@(posedge pllClk_i) disable iff (reset_complete)
        $rose(bus.cs_n) |-> io_complete);

endmodule

/* logic/io_module.sv */
`timescale 1ns/1ps

module io_module #(
    parameter int SCLK_DIV = 2                    // Passed to the shift engine
) (
    input  logic                  pllClk_i,
    input  logic                  reset_complete,
    // Host port
    input  logic                  tx_wr,
    input  spi_bus_pkg::addr_t    tx_addr,
    input  spi_bus_pkg::byte_t    tx_byte,
    input  logic                  rx_rd,
    input  spi_bus_pkg::addr_t    rx_addr,
    output spi_bus_pkg::byte_t    rx_byte,
    input  logic                  send,
    input  spi_bus_pkg::len_t     len,        // Held by host for whole transfer
    output logic                  io_complete,
    // SPI side
    input  logic                  miso,
    output spi_bus_pkg::spi_bus_t bus
);

    import spi_bus_pkg::*;

    addr_t sh_idx;          // Index requested by shifter
    logic  sh_rx_wr;
    byte_t sh_rx_byte;
    byte_t sh_tx_byte;
    logic  active;          // Transfer in flight
    logic  host_wr;

    assign host_wr = tx_wr & ~active;         // Buffer locked while shifting

    always_ff @(posedge pllClk_i) begin
        if (reset_complete)   active <= 1'b0;
        else if (io_complete) active <= 1'b0;
        else if (send)        active <= 1'b1;
    end

    // ------------------------------
    // Byte buffers
    // ------------------------------
    io_buffer io_buffer_i (
        .pllClk_i  (pllClk_i),
        .tx_wr     (host_wr),
        .tx_addr   (tx_addr),
        .tx_byte   (tx_byte),
        .rx_rd     (rx_rd),
        .rx_addr   (rx_addr),
        .rx_byte   (rx_byte),
        .sh_addr   (sh_idx),
        .sh_rx_wr  (sh_rx_wr),
        .sh_rx_byte(sh_rx_byte),
        .sh_tx_byte(sh_tx_byte)
    );

    // ------------------------------
    // Shift engine
    // ------------------------------
    spi_shifter #(
        .SCLK_DIV(SCLK_DIV)
    ) spi_shifter_i (
        .pllClk_i      (pllClk_i),
        .reset_complete(reset_complete),
        .send          (send),
        .len           (len),
        .tx_byte       (sh_tx_byte),
        .miso          (miso),
        .idx           (sh_idx),
        .rx_wr         (sh_rx_wr),
        .rx_byte       (sh_rx_byte),
        .io_complete   (io_complete),
        .bus           (bus)
    );

    a_no_host_wr: assert property (@(posedge pllClk_i) disable iff (reset_complete)
        active |-> !tx_wr);

endmodule

/* logic/transfer_sequencer.sv */
`timescale 1ns/1ps

module transfer_sequencer (
    input  logic                  pllClk_i,
    input  logic                  reset_complete,
    input  logic                  start,          // Taken only when idle
    input  spi_io_pkg::xfer_req_t req,
    output logic                  busy,
    output logic                  done,
    output spi_io_pkg::xfer_rsp_t rsp,            // Holds until next done
    // To I/O module
    output logic                  tx_wr,
    output spi_bus_pkg::addr_t    tx_addr,
    output spi_bus_pkg::byte_t    tx_byte,
    output logic                  send,
    output spi_bus_pkg::len_t     len,
    input  logic                  io_complete,
    output logic                  rx_rd,
    output spi_bus_pkg::addr_t    rx_addr,
    input  spi_bus_pkg::byte_t    rx_byte
);

    import spi_bus_pkg::*;
    import spi_io_pkg::*;

    seq_state_t            state;
    xfer_req_t             req_q;                 // Latched request
    len_t                  cnt;                   // Byte counter, 0..len
    byte_t [MAX_BYTES-1:0] gather_q;
    byte_t [MAX_BYTES-1:0] gather_d;
    addr_t                 prev_addr;             // Byte whose read data lands now

    assign busy      = (state != SEQ_IDLE);
    assign len       = req_q.len;
    assign tx_wr     = (state == SEQ_WRITE);
    assign tx_addr   = addr_t'(cnt);
    assign tx_byte   = req_q.data[tx_addr];
    assign send      = (state == SEQ_SEND);
    assign rx_rd     = (state == SEQ_READ) && (cnt < req_q.len);
    assign rx_addr   = addr_t'(cnt);
    assign prev_addr = addr_t'(cnt - len_t'(1));

    // Merge registered read data, one cycle behind rx_rd
    always_comb begin
        gather_d = gather_q;
        if (state == SEQ_READ && cnt != '0) gather_d[prev_addr] = rx_byte;
    end

    // ------------------------------
    // Control FSM
    // ------------------------------
    always_ff @(posedge pllClk_i) begin
        if (reset_complete) begin
            state <= SEQ_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    cnt <= '0;
                    if (start) state <= SEQ_WRITE;
                end
                SEQ_WRITE: begin                  // One byte per cycle
                    if (cnt == req_q.len - len_t'(1)) begin
                        cnt   <= '0;
                        state <= SEQ_SEND;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SEQ_SEND: state <= SEQ_WAIT;
                SEQ_WAIT: if (io_complete) state <= SEQ_READ;
                SEQ_READ: begin                   // len reads plus one to catch the last
                    if (cnt == req_q.len) begin
                        cnt   <= '0;
                        done  <= 1'b1;            // busy drops on this same edge
                        state <= SEQ_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Request latch and result assembly
    always_ff @(posedge pllClk_i) begin
        if (state == SEQ_IDLE && start) begin
            req_q    <= req;
            gather_q <= '0;
        end else begin
            gather_q <= gather_d;
        end
        if (state == SEQ_READ && cnt == req_q.len) begin
            rsp <= '{len: req_q.len, data: gather_d};
        end
    end

    a_complete_waited: assert property (@(posedge pllClk_i) disable iff (reset_complete)
        io_complete |-> state == SEQ_WAIT);

endmodule

/* logic/spi_target.sv */
`timescale 1ns/1ps

module spi_target #(
    parameter spi_bus_pkg::byte_t TARGET_FIRST = 8'hA5   // Reply for byte 0
) (
    input  logic                  pllClk_i,
    input  logic                  reset_complete,
    input  spi_bus_pkg::spi_bus_t bus,
    output logic                  miso
);

    import spi_bus_pkg::*;

    logic       sclk_q;           // Previous sclk, edge detect
    logic       cs_n_q;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_fall;
    logic [2:0] bit_cnt;          // Wraps to 0 after each byte
    byte_t      tx_sh;
    byte_t      rx_sh;

    assign sclk_rise = bus.sclk & ~sclk_q & ~bus.cs_n;
    assign sclk_fall = ~bus.sclk & sclk_q & ~bus.cs_n;
    assign cs_fall   = ~bus.cs_n & cs_n_q;
    assign miso      = tx_sh[7];

    // ------------------------------
    // Reply shifter
    // ------------------------------
    always_ff @(posedge pllClk_i) begin
        if (reset_complete) begin
            sclk_q  <= 1'b0;
            cs_n_q  <= 1'b1;
            bit_cnt <= '0;
            tx_sh   <= '0;
        end else begin
            sclk_q <= bus.sclk;
            cs_n_q <= bus.cs_n;
            if (cs_fall) begin
                tx_sh   <= TARGET_FIRST;      // First bit out right at select
                bit_cnt <= '0;
            end else begin
                if (sclk_rise) bit_cnt <= bit_cnt + 1'b1;
                if (sclk_fall) begin
                    // Byte just finished, answer with its complement
                    if (bit_cnt == 3'd0) tx_sh <= ~rx_sh;
                    else                 tx_sh <= {tx_sh[6:0], 1'b0};
                end
            end
        end
    end

    always_ff @(posedge pllClk_i) begin
        if (sclk_rise) rx_sh <= {rx_sh[6:0], bus.mosi};   // MSB first
    end

endmodule

/* logic/spi_io_top.sv */
`timescale 1ns/1ps

module spi_io_top #(
    parameter int                 SCLK_DIV     = 2,
    parameter spi_bus_pkg::byte_t TARGET_FIRST = 8'hA5
) (
    input  logic                  pllClk_i,
    input  logic                  reset_complete,
    input  logic                  start,
    input  spi_io_pkg::xfer_req_t req,
    output logic                  busy,
    output logic                  done,
    output spi_io_pkg::xfer_rsp_t rsp
);

    import spi_bus_pkg::*;

    // ------------------------------
    // Host to I/O module
    // ------------------------------
    logic     tx_wr;
    addr_t    tx_addr;
    byte_t    tx_byte;
    logic     rx_rd;
    addr_t    rx_addr;
    byte_t    rx_byte;
    logic     send;
    len_t     len;
    logic     io_complete;
    spi_bus_t bus;            // Master to target
    logic     miso;

    transfer_sequencer transfer_sequencer_i (
        .pllClk_i      (pllClk_i),
        .reset_complete(reset_complete),
        .start         (start),
        .req           (req),
        .busy          (busy),
        .done          (done),
        .rsp           (rsp),
        .tx_wr         (tx_wr),
        .tx_addr       (tx_addr),
        .tx_byte       (tx_byte),
        .send          (send),
        .len           (len),
        .io_complete   (io_complete),
        .rx_rd         (rx_rd),
        .rx_addr       (rx_addr),
        .rx_byte       (rx_byte)
    );

    io_module #(
        .SCLK_DIV(SCLK_DIV)
    ) io_module_i (
        .pllClk_i      (pllClk_i),
        .reset_complete(reset_complete),
        .tx_wr         (tx_wr),
        .tx_addr       (tx_addr),
        .tx_byte       (tx_byte),
        .rx_rd         (rx_rd),
        .rx_addr       (rx_addr),
        .rx_byte       (rx_byte),
        .send          (send),
        .len           (len),
        .io_complete   (io_complete),
        .miso          (miso),
        .bus           (bus)
    );

    // Simulated device on the far end
    spi_target #(
        .TARGET_FIRST(TARGET_FIRST)
    ) spi_target_i (
        .pllClk_i      (pllClk_i),
        .reset_complete(reset_complete),
        .bus           (bus),
        .miso          (miso)
    );

endmodule

/* tb/spi_io_tb.sv */
`timescale 1ns/1ps

module spi_io_tb #(
    parameter int                 SCLK_DIV     = 2,
    parameter spi_bus_pkg::byte_t TARGET_FIRST = 8'hA5
);

    import spi_bus_pkg::*;
    import spi_io_pkg::*;

    localparam int NUM_ROWS = 10;
    localparam int ROW_CYC  = MAX_BYTES * 8 * 2 * SCLK_DIV + 40;  // Longest row plus slack
    localparam int LIMIT    = NUM_ROWS * ROW_CYC;
    localparam int POKE_AT  = 6;          // Wait cycle of the stray start

    logic      pllClk_i;
    logic      reset_complete;
    logic      start;
    xfer_req_t req;
    logic      busy;
    logic      done;
    xfer_rsp_t rsp;

    xfer_req_t table_req  [NUM_ROWS];
    logic      table_poke [NUM_ROWS];     // Extra start while busy
    integer    seed;
    integer    errors;
    integer    checks;
    integer    cycle_cnt;

    spi_io_top #(
        .SCLK_DIV    (SCLK_DIV),
        .TARGET_FIRST(TARGET_FIRST)
    ) spi_io_top_i (
        .pllClk_i      (pllClk_i),
        .reset_complete(reset_complete),
        .start         (start),
        .req           (req),
        .busy          (busy),
        .done          (done),
        .rsp           (rsp)
    );

    initial begin
        pllClk_i = 1'b0;
        forever #5 pllClk_i = ~pllClk_i;  // 10 ns period
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_bit(input string name, input logic exp, input logic act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERROR %0t ns %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_rsp(input xfer_rsp_t exp, input xfer_rsp_t act);
        int k;
        checks = checks + 1;
        if (act.len !== exp.len) begin
            errors = errors + 1;
            $display("ERROR %0t ns rsp.len expected %0d got %0d", $time, exp.len, act.len);
        end
        for (k = 0; k < int'(exp.len); k++) begin     // Bytes past len are don't care
            if (act.data[k] !== exp.data[k]) begin
                errors = errors + 1;
                $display("ERROR %0t ns rsp.data[%0d] expected %02h got %02h",
                         $time, k, exp.data[k], act.data[k]);
            end
        end
    endtask

    // Target rule, first byte fixed, then complement of previous sent byte
    function automatic xfer_rsp_t expected_rsp(input xfer_req_t r);
        xfer_rsp_t e;
        int        k;
        e         = '0;
        e.len     = r.len;
        e.data[0] = TARGET_FIRST;
        for (k = 1; k < int'(r.len); k++) begin
            e.data[k] = ~r.data[k-1];
        end
        return e;
    endfunction

    function automatic xfer_req_t make_req(input len_t n, input byte_t b0, input byte_t b1,
                                           input byte_t b2, input byte_t b3);
        xfer_req_t r;
        r.len     = n;
        r.data[0] = b0;
        r.data[1] = b1;
        r.data[2] = b2;
        r.data[3] = b3;
        return r;
    endfunction

    // ------------------------------
    // Stimulus table
    // ------------------------------
    task automatic build_table();
        int i;
        int k;
        table_req[0]  = make_req(3'd1, 8'h3C, 8'h00, 8'h00, 8'h00);   // Single byte
        table_req[1]  = make_req(3'd4, 8'h01, 8'h80, 8'hFF, 8'h5A);   // Full buffer
        table_req[2]  = make_req(3'd2, 8'h00, 8'hC3, 8'h00, 8'h00);
        table_req[3]  = make_req(3'd3, 8'h96, 8'h69, 8'h0F, 8'h00);
        table_poke[0] = 1'b0;
        table_poke[1] = 1'b0;
        table_poke[2] = 1'b0;
        table_poke[3] = 1'b1;             // Stray start mid transfer
        for (i = 4; i < NUM_ROWS; i++) begin
            table_req[i].len = len_t'(($random(seed) & 3) + 1);
            for (k = 0; k < MAX_BYTES; k++) begin
                table_req[i].data[k] = byte_t'($random(seed));
            end
            table_poke[i] = (i == 7);
        end
    endtask

    task automatic run_row(input int row);
        xfer_req_t r;
        xfer_rsp_t exp;
        logic      got;
        int        waited;
        r   = table_req[row];
        exp = expected_rsp(r);
        @(posedge pllClk_i);
        #1;
        start = 1'b1;
        req   = r;
        @(negedge pllClk_i);
        check_bit("busy", 1'b0, busy);    // Not sampled yet
        check_bit("done", 1'b0, done);
        @(posedge pllClk_i);
        #1;
        start = 1'b0;
        req   = '0;                        // Must already be latched
        @(negedge pllClk_i);
        check_bit("busy", 1'b1, busy);
        got    = 1'b0;
        waited = 0;
        while (!got) begin
            @(posedge pllClk_i);
            #1;
            if (table_poke[row] && waited == POKE_AT) begin
                start = 1'b1;
                req   = xfer_req_t'(~r);   // Different request, should be dropped
            end else begin
                start = 1'b0;
                req   = '0;
            end
            @(negedge pllClk_i);
            waited = waited + 1;
            got    = done;
            if (!got) check_bit("busy", 1'b1, busy);
        end
        check_bit("busy", 1'b0, busy);    // Falls with done
        check_rsp(exp, rsp);
        // One-cycle pulse, no second transfer
        repeat (3) begin
            @(negedge pllClk_i);
            check_bit("done", 1'b0, done);
            check_bit("busy", 1'b0, busy);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int row;
        errors         = 0;
        checks         = 0;
        seed           = 72786;
        start          = 1'b0;
        req            = '0;
        reset_complete = 1'b1;
        build_table();
        repeat (10) @(posedge pllClk_i);
        #1;
        reset_complete = 1'b0;
        repeat (5) begin                   // Quiet until first start
            @(negedge pllClk_i);
            check_bit("busy", 1'b0, busy);
            check_bit("done", 1'b0, done);
        end
        for (row = 0; row < NUM_ROWS; row++) begin
            run_row(row);
        end
        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog over the whole run
    initial begin
        cycle_cnt = 0;
        @(negedge reset_complete);
        while (cycle_cnt < LIMIT) begin
            @(posedge pllClk_i);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout after %0d cycles, a transfer never completed", cycle_cnt);
        $display("Test failures found");
        $finish;
    end

endmodule

/* spi_io.f */
logic/spi_bus_pkg.sv
logic/spi_io_pkg.sv
logic/io_buffer.sv
logic/spi_shifter.sv
logic/io_module.sv
logic/transfer_sequencer.sv
logic/spi_target.sv
logic/spi_io_top.sv
tb/spi_io_tb.sv

/* Makefile */
# Verilator build and run for the SPI I/O subsystem

VERILATOR ?= verilator
TOP       ?= spi_io_tb
FLIST     ?= spi_io.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SCLK_DIV  ?= 2
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSCLK_DIV=$(SCLK_DIV) \
		--Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

check:
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
